// ==== verilog/fp_arith_params.svh ====
`ifndef FP_ARITH_PARAMS_SVH
`define FP_ARITH_PARAMS_SVH

// Q16.16 word layout
`define FP_WIDTH 32
`define FP_INT_WIDTH 16
`define FP_FRAC_WIDTH 16

// One quotient bit per cycle over the dividend and its fraction extension
`define FP_DIV_ITERS (`FP_WIDTH + `FP_FRAC_WIDTH)

`endif

// ==== verilog/fp_arith_pkg.sv ====
`include "fp_arith_params.svh"

package fp_arith_pkg;

  // One Q16.16 value
  typedef logic [`FP_WIDTH-1:0] fp_word_t;

  // Operation selector
  typedef enum logic {
    FP_OP_MUL = 1'b0,
    FP_OP_DIV = 1'b1
  } fp_op_e;

  // Request as presented by the caller, held stable while go is high
  typedef struct packed {
    fp_op_e   op;
    logic     is_signed;
    fp_word_t left;
    fp_word_t right;
  } fp_req_t;

endpackage

// ==== verilog/fp_mult_pipe.sv ====
`timescale 1ns/1ps
`include "fp_arith_params.svh"

module fp_mult_pipe (
  input  logic                   clk,
  input  logic                   reset,
  input  logic                   go,
  input  logic                   is_signed,
  input  fp_arith_pkg::fp_word_t left,
  input  fp_arith_pkg::fp_word_t right,
  output fp_arith_pkg::fp_word_t product,
  output logic                   done
);

  localparam int W = `FP_WIDTH;
  localparam int INT_W = `FP_INT_WIDTH;

  fp_arith_pkg::fp_word_t ltmp;
  fp_arith_pkg::fp_word_t rtmp;
  logic                   sign_q;
  logic [2*W-1:0]         lext;
  logic [2*W-1:0]         rext;
  logic [2*W-1:0]         prod_q;
  logic [1:0]             done_sr;

  // Stage 1 captures the operands and the signed mode together
  always_ff @(posedge clk) begin
    if (go) begin
      ltmp <= left;
      rtmp <= right;
      sign_q <= is_signed;
    end
  end

  // Sign extension only in signed mode, zero extension otherwise
  assign lext = {{W{sign_q & ltmp[W-1]}}, ltmp};
  assign rext = {{W{sign_q & rtmp[W-1]}}, rtmp};

  // Stage 2 product
  // On the first go edge this still sees stale operands, overwritten on the next edge
  always_ff @(posedge clk) begin
    if (go) begin
      prod_q <= lext * rext;
    end
  end

  // Drop the extra fraction bits and keep one word of the product
  assign product = prod_q[2*W-INT_W-1 -: W];

  // Done walks with go through both stages and drops as soon as go falls
  always_ff @(posedge clk) begin
    if (reset) begin
      done_sr <= '0;
    end else begin
      done_sr <= {done_sr[0] & go, go};
    end
  end

  assign done = done_sr[1];

  // A product is only valid after two edges of go
  assert property (@(posedge clk) disable iff (reset)
    $rose(done) |-> $past(go, 1) && $past(go, 2))
  else $error("fp_mult_pipe: done without two cycles of go");

endmodule

// ==== verilog/fp_div_iter.sv ====
`timescale 1ns/1ps
`include "fp_arith_params.svh"

module fp_div_iter (
  input  logic                   clk,
  input  logic                   reset,
  input  logic                   go,
  input  fp_arith_pkg::fp_word_t dividend,
  input  fp_arith_pkg::fp_word_t divisor,
  output fp_arith_pkg::fp_word_t quotient,
  output logic                   done
);

  localparam int W = `FP_WIDTH;
  localparam int ITERS = `FP_DIV_ITERS;
  localparam int IDX_W = $clog2(ITERS);

  logic                   running;
  logic [IDX_W-1:0]       idx;
  logic                   start;
  logic                   dividend_is_zero;
  logic                   finished;

  // Partial remainder with the next dividend bit already shifted in
  logic [W:0]             acc;
  logic [W:0]             acc_next;
  logic [W:0]             acc_diff;
  logic                   acc_ge;
  fp_arith_pkg::fp_word_t rem;
  // Dividend bits not yet consumed, zeros follow for the fraction part
  fp_arith_pkg::fp_word_t dvd;
  fp_arith_pkg::fp_word_t dvd_next;
  fp_arith_pkg::fp_word_t quot;
  fp_arith_pkg::fp_word_t quot_next;

  assign start = go && !running;
  assign dividend_is_zero = start && (dividend == '0);
  assign finished = running && (idx == IDX_W'(ITERS - 1));

  // One restoring step
  always_comb begin
    acc_diff = acc - {1'b0, divisor};
    acc_ge = (acc >= {1'b0, divisor});
    // Remainder is below the divisor so it fits a word
    rem = acc_ge ? acc_diff[W-1:0] : acc[W-1:0];
    acc_next = {rem, dvd[W-1]};
    dvd_next = {dvd[W-2:0], 1'b0};
    quot_next = {quot[W-2:0], acc_ge};
  end

  always_ff @(posedge clk) begin
    if (reset || finished || dividend_is_zero) begin
      running <= 1'b0;
    end else if (start) begin
      running <= 1'b1;
    end
  end

  always_ff @(posedge clk) begin
    if (reset || !running) begin
      idx <= '0;
    end else begin
      idx <= idx + 1'b1;
    end
  end

  // Datapath load on start, then one quotient bit per cycle
  always_ff @(posedge clk) begin
    if (start) begin
      acc <= {{W{1'b0}}, dividend[W-1]};
      dvd <= {dividend[W-2:0], 1'b0};
      quot <= '0;
    end else if (running) begin
      acc <= acc_next;
      dvd <= dvd_next;
      quot <= quot_next;
    end
  end

  // Result register, cleared on start and kept while go is low
  always_ff @(posedge clk) begin
    if (start) begin
      quotient <= '0;
    end else if (go && finished) begin
      quotient <= quot_next;
    end
  end

  // Single cycle pulse at the end of a division or on a zero dividend
  always_ff @(posedge clk) begin
    if (reset) begin
      done <= 1'b0;
    end else begin
      done <= finished || dividend_is_zero;
    end
  end

  assert property (@(posedge clk) disable iff (reset)
    running |-> idx <= IDX_W'(ITERS - 1))
  else $error("fp_div_iter: iteration counter overran");

endmodule

// ==== verilog/fp_signed_div.sv ====
`timescale 1ns/1ps
`include "fp_arith_params.svh"

module fp_signed_div (
  input  logic                   clk,
  input  logic                   reset,
  input  logic                   go,
  input  logic                   is_signed,
  input  fp_arith_pkg::fp_word_t left,
  input  fp_arith_pkg::fp_word_t right,
  output fp_arith_pkg::fp_word_t quotient,
  output logic                   done
);

  localparam int W = `FP_WIDTH;

  fp_arith_pkg::fp_word_t left_abs;
  fp_arith_pkg::fp_word_t right_abs;
  fp_arith_pkg::fp_word_t core_quotient;
  logic                   negate_q;

  // Magnitudes in signed mode, raw operands otherwise
  assign left_abs = (is_signed && left[W-1]) ? -left : left;
  assign right_abs = (is_signed && right[W-1]) ? -right : right;

  // Sign of the result kept past the fall of go
  always_ff @(posedge clk) begin
    if (reset) begin
      negate_q <= 1'b0;
    end else if (go) begin
      negate_q <= is_signed && (left[W-1] ^ right[W-1]);
    end
  end

  assign quotient = negate_q ? -core_quotient : core_quotient;

  fp_div_iter core0 (
    .clk      (clk),
    .reset    (reset),
    .go       (go),
    .dividend (left_abs),
    .divisor  (right_abs),
    .quotient (core_quotient),
    .done     (done)
  );

  // Division by zero has no defined result
  assert property (@(posedge clk) disable iff (reset)
    $rose(go) |-> right != '0)
  else $error("fp_signed_div: division started with a zero divisor");

endmodule

// ==== verilog/fp_arith_unit.sv ====
`timescale 1ns/1ps

module fp_arith_unit (
  input  logic                   clk,
  input  logic                   reset,
  input  logic                   go,
  input  fp_arith_pkg::fp_req_t  req,
  output fp_arith_pkg::fp_word_t result,
  output logic                   done
);

  logic                   go_mul;
  logic                   go_div;
  logic                   mul_done;
  logic                   div_done;
  fp_arith_pkg::fp_word_t mul_product;
  fp_arith_pkg::fp_word_t div_quotient;
  fp_arith_pkg::fp_op_e   op_q;

  // Only the engine named by the request sees go
  assign go_mul = go && (req.op == fp_arith_pkg::FP_OP_MUL);
  assign go_div = go && (req.op == fp_arith_pkg::FP_OP_DIV);

  // Operation of the request in flight, so the result holds after go falls
  always_ff @(posedge clk) begin
    if (reset) begin
      op_q <= fp_arith_pkg::FP_OP_MUL;
    end else if (go) begin
      op_q <= req.op;
    end
  end

  fp_mult_pipe mult0 (
    .clk       (clk),
    .reset     (reset),
    .go        (go_mul),
    .is_signed (req.is_signed),
    .left      (req.left),
    .right     (req.right),
    .product   (mul_product),
    .done      (mul_done)
  );

  fp_signed_div div0 (
    .clk       (clk),
    .reset     (reset),
    .go        (go_div),
    .is_signed (req.is_signed),
    .left      (req.left),
    .right     (req.right),
    .quotient  (div_quotient),
    .done      (div_done)
  );

  assign result = (op_q == fp_arith_pkg::FP_OP_DIV) ? div_quotient : mul_product;
  assign done = mul_done | div_done;

  // Engines sample the request over several cycles
  assert property (@(posedge clk) disable iff (reset)
    go && !done |=> !go || $stable(req))
  else $error("fp_arith_unit: request changed while an operation was pending");

endmodule

// ==== dv/fp_arith_tb.sv ====
`timescale 1ns/1ps
`include "fp_arith_params.svh"

module fp_arith_tb;

  localparam int NUM_PATTERNS = 34;
  localparam int NUM_RANDOM = 8;
  localparam int FIELDS = 5;
  localparam int MUL_EDGES = 2;
  // Start edge plus one edge per quotient bit
  localparam int DIV_EDGES = `FP_DIV_ITERS + 1;
  localparam int ZERO_DIV_EDGES = 1;
  localparam int WATCHDOG_CYCLES =
    (NUM_PATTERNS + NUM_RANDOM) * (`FP_DIV_ITERS + 4) + 100;

  logic                   clk;
  logic                   reset;
  logic                   go;
  fp_arith_pkg::fp_req_t  req;
  fp_arith_pkg::fp_word_t result;
  logic                   done;

  // Five words per request in the order op, is_signed, left, right, expected
  logic [31:0] patterns [0:NUM_PATTERNS*FIELDS-1];
  int          seed;
  logic        go_prev;
  logic        done_prev;

  fp_arith_unit dut0 (
    .clk    (clk),
    .reset  (reset),
    .go     (go),
    .req    (req),
    .result (result),
    .done   (done)
  );

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  task automatic abort_run(string reason);
    $display("%s", reason);
    $display("*** TEST FAILED ***");
    $fatal(1, "simulation stopped at the first error");
  endtask

  task automatic check_word(fp_arith_pkg::fp_word_t got, fp_arith_pkg::fp_word_t exp,
                            string what);
    if (got !== exp) begin
      abort_run($sformatf("MISMATCH at %0d ns: %s result %h, expected %h",
                          $time, what, got, exp));
    end
  endtask

  task automatic check_done(logic got, logic exp, string what);
    if (got !== exp) begin
      abort_run($sformatf("MISMATCH at %0d ns: %s done %b, expected %b",
                          $time, what, got, exp));
    end
  endtask

  // Edges from the first edge with go high to the edge after which done is seen
  function automatic int expected_edges(fp_arith_pkg::fp_req_t r);
    int edges;
    if (r.op == fp_arith_pkg::FP_OP_MUL) begin
      edges = MUL_EDGES;
    end else if (r.left == '0) begin
      edges = ZERO_DIV_EDGES;
    end else begin
      edges = DIV_EDGES;
    end
    return edges;
  endfunction

  // Q16.16 slice of the full unsigned product
  function automatic fp_arith_pkg::fp_word_t unsigned_product(fp_arith_pkg::fp_word_t a,
                                                              fp_arith_pkg::fp_word_t b);
    logic [2*`FP_WIDTH-1:0] full;
    full = {{`FP_WIDTH{1'b0}}, a} * {{`FP_WIDTH{1'b0}}, b};
    return full[`FP_WIDTH+`FP_FRAC_WIDTH-1 -: `FP_WIDTH];
  endfunction

  // Entered and left 1 ns after a rising edge
  task automatic run_request(fp_arith_pkg::fp_req_t r, fp_arith_pkg::fp_word_t exp,
                             string what);
    int edges;
    int lat;
    lat = expected_edges(r);
    edges = 0;
    req = r;
    go = 1'b1;
    while (edges < lat) begin
      @(posedge clk);
      #1;
      edges++;
      check_done(done, edges == lat, what);
    end
    check_word(result, exp, what);
    go = 1'b0;
    @(posedge clk);
    #1;
    check_done(done, 1'b0, {what, " after go fell"});
    check_word(result, exp, {what, " held after go fell"});
  endtask

  // Done may only rise on an edge that saw go high
  initial begin
    go_prev = 1'b0;
    done_prev = 1'b0;
    forever begin
      @(negedge clk);
      if (!reset && done && !done_prev && !go_prev) begin
        abort_run("done went high although go was low on that clock edge");
      end
      done_prev = done;
      go_prev = go;
    end
  end

  initial begin
    repeat (WATCHDOG_CYCLES) @(posedge clk);
    $display("Timeout: the run did not finish within %0d clock cycles", WATCHDOG_CYCLES);
    $display("*** TEST FAILED ***");
    $fatal(1, "watchdog expired");
  end

  initial begin
    int                     base;
    fp_arith_pkg::fp_req_t  r;
    fp_arith_pkg::fp_word_t a;
    fp_arith_pkg::fp_word_t b;

    reset = 1'b1;
    go = 1'b0;
    req = '0;
    seed = 14604;

    $readmemh("dv/fp_arith_patterns.hex", patterns);
    for (int i = 0; i < NUM_PATTERNS * FIELDS; i++) begin
      if ($isunknown(patterns[i])) begin
        abort_run("The pattern file dv/fp_arith_patterns.hex is missing or too short");
      end
    end

    repeat (2) @(posedge clk);
    #1;
    reset = 1'b0;

    // Idle unit after reset
    repeat (2) begin
      @(posedge clk);
      #1;
      check_done(done, 1'b0, "idle after reset");
    end

    for (int i = 0; i < NUM_PATTERNS; i++) begin
      base = i * FIELDS;
      r.op = fp_arith_pkg::fp_op_e'(patterns[base][0]);
      r.is_signed = patterns[base+1][0];
      r.left = patterns[base+2];
      r.right = patterns[base+3];
      run_request(r, patterns[base+4], $sformatf("pattern %0d", i));
    end

    // Unsigned multiply on random operands
    for (int i = 0; i < NUM_RANDOM; i++) begin
      a = $random(seed);
      b = $random(seed);
      r.op = fp_arith_pkg::FP_OP_MUL;
      r.is_signed = 1'b0;
      r.left = a;
      r.right = b;
      run_request(r, unsigned_product(a, b), $sformatf("random multiply %0d", i));
    end

    $display("*** TEST PASSED ***");
    $finish;
  end

endmodule

// ==== dv/fp_arith_patterns.hex ====
// Columns: op (0 multiply, 1 divide), is_signed, left, right, expected result
// Operands and results are Q16.16 words in hex
0 0 00020000 00030000 00060000
1 0 00060000 00020000 00030000
0 0 00018000 00028000 0003C000
1 0 00010000 00040000 00004000
0 0 00008000 00008000 00004000
1 0 00010000 00030000 00005555
1 0 00000000 00030000 00000000
0 0 FFFF0000 00020000 FFFE0000
1 0 00078000 00008000 000F0000
0 0 FFFFFFFF 00010000 FFFFFFFF
1 0 FFFF0000 00010000 FFFF0000
0 1 FFFE0000 00030000 FFFA0000
1 1 FFFA0000 00020000 FFFD0000
0 1 FFFE8000 FFFE0000 00030000
1 1 00060000 FFFE0000 FFFD0000
0 1 FFFF8000 00004000 FFFFE000
1 1 FFFA0000 FFFE0000 00030000
0 1 00010000 FFFF0000 FFFF0000
1 1 FFFF0000 00030000 FFFFAAAB
0 0 FFFF8000 00004000 3FFFE000
1 1 00010000 00030000 00005555
0 1 FFFFFFFF 00008000 FFFFFFFF
1 1 FFF88000 FFFF8000 000F0000
0 0 00012345 00010000 00012345
1 0 00100000 00000100 10000000
0 1 7FFF0000 00020000 FFFE0000
1 0 FFFFFFFF FFFFFFFF 00010000
1 1 00000000 FFFE0000 00000000
1 0 00000001 00000007 00002492
0 1 FFFF0000 FFFF0000 00010000
1 0 FFFE0000 00020000 7FFF0000
0 0 00000003 00008000 00000001
1 1 00018000 FFFF8000 FFFD0000
1 0 00000003 00020000 00000001

// ==== filelist.f ====
+incdir+verilog
verilog/fp_arith_pkg.sv
verilog/fp_mult_pipe.sv
verilog/fp_div_iter.sv
verilog/fp_signed_div.sv
verilog/fp_arith_unit.sv
dv/fp_arith_tb.sv

// ==== Bender.yml ====
package:
  name: fp_arith

sources:
  - include_dirs:
      - verilog
    files:
      - verilog/fp_arith_pkg.sv
      - verilog/fp_mult_pipe.sv
      - verilog/fp_div_iter.sv
      - verilog/fp_signed_div.sv
      - verilog/fp_arith_unit.sv
  - target: test
    include_dirs:
      - verilog
    files:
      - dv/fp_arith_tb.sv
